// ==== logic/div_bit_counter.sv ====
//////////////////////////////////////////////////
// Bit position down-counter for the COMP loop
// Gives the bit index and the last-iteration flag
//////////////////////////////////////////////////

`default_nettype none

module div_bit_counter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  div_ctrl_if.cnt_mp                ctrl,
  output logic [div_pkg::CNT_W-1:0] bit_idx_o
);

  import div_pkg::*;

  logic [CNT_W-1:0] cnt_q, cnt_d;

  always_comb begin
    cnt_d = cnt_q;
    case (ctrl.state)
      // Reload to the MSB until iterations start
      IDLE, ABS_A, ABS_B: cnt_d = CNT_W'(XLEN - 1);
      COMP:               cnt_d = cnt_q - CNT_W'(1);
      default:            cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ctrl.step_en) begin
      cnt_q <= cnt_d;
    end
  end

  assign bit_idx_o     = cnt_q;
  assign ctrl.cnt_last = (cnt_q == CNT_W'(1));

  // FSM must leave COMP before bit 0
  a_no_underrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl.state == COMP) |-> (cnt_q != '0));

endmodule

`default_nettype wire

// ==== logic/div_ctrl_if.sv ====
//////////////////////////////////////////////////
// Control bundle from the divider FSM to the
// datapath and the bit counter, with status back
//////////////////////////////////////////////////

`default_nettype none

interface div_ctrl_if;

  import div_pkg::*;

  // Current FSM state
  div_state_e state;
  // State register advances this cycle
  logic       step_en;
  // Divisor was zero when the division started
  logic       div_by_zero_q;
  // Counter sits on the last COMP iteration
  logic       cnt_last;

  modport fsm_mp (
    output state,
    output step_en,
    input  div_by_zero_q,
    input  cnt_last
  );

  modport dp_mp (
    input  state,
    input  step_en,
    output div_by_zero_q
  );

  modport cnt_mp (
    input  state,
    input  step_en,
    output cnt_last
  );

endinterface

`default_nettype wire

// ==== logic/div_datapath.sv ====
//////////////////////////////////////////////////
// Divider working registers and shared subtractor
// Restoring radix-2 on magnitudes, sign fix at end
//////////////////////////////////////////////////

`default_nettype none

module div_datapath (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  div_ctrl_if.dp_mp                 ctrl,
  input  div_pkg::div_op_e          op_i,
  input  logic [div_pkg::XLEN-1:0]  operand_a_i,
  input  logic [div_pkg::XLEN-1:0]  operand_b_i,
  input  logic [div_pkg::CNT_W-1:0] bit_idx_i,
  output logic                      divisor_zero_o,
  output logic [div_pkg::XLEN-1:0]  result_o
);

  import div_pkg::*;

  logic [XLEN-1:0]  numer_q, numer_d;
  logic [XLEN-1:0]  denom_q, denom_d;
  logic [XLEN-1:0]  rem_q, rem_d;
  logic [XLEN-1:0]  quot_q, quot_d;
  logic             dbz_q, dbz_d;
  logic [XLEN-1:0]  sub_a, sub_b;
  logic [XLEN:0]    sub_res;
  logic             is_signed, is_rem;
  logic             sign_a, sign_b;
  logic             quot_neg, rem_neg;
  logic             ge;
  logic [XLEN-1:0]  quot_bit;
  logic [XLEN-1:0]  next_rem, next_quot;
  logic [CNT_W-1:0] shift_idx;

  assign is_signed      = op_is_signed(op_i);
  assign is_rem         = op_is_rem(op_i);
  assign sign_a         = operand_a_i[XLEN-1] & is_signed;
  assign sign_b         = operand_b_i[XLEN-1] & is_signed;
  // Quotient keeps all ones on a zero divisor
  assign quot_neg       = (sign_a ^ sign_b) & ~dbz_q;
  // Remainder follows the dividend sign
  assign rem_neg        = sign_a;
  assign divisor_zero_o = ~|operand_b_i;

  //////////////////////////////////////////////////
  // Shared subtractor
  //////////////////////////////////////////////////

  always_comb begin
    sub_a = '0;
    sub_b = '0;
    case (ctrl.state)
      // 0 - x gives the negation
      ABS_A: sub_b = operand_a_i;
      ABS_B: sub_b = operand_b_i;
      COMP, LAST: begin
        sub_a = rem_q;
        sub_b = denom_q;
      end
      CHANGE_SIGN: sub_b = is_rem ? rem_q : quot_q;
      default: sub_b = '0;
    endcase
  end

  // Extra bit is the borrow
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  assign ge      = ~sub_res[XLEN];

  // Trial step results
  assign quot_bit  = XLEN'(1) << bit_idx_i;
  assign next_rem  = ge ? sub_res[XLEN-1:0] : rem_q;
  assign next_quot = ge ? (quot_q | quot_bit) : quot_q;
  // Next dividend bit to shift in
  assign shift_idx = bit_idx_i - CNT_W'(1);

  //////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////

  always_comb begin
    numer_d = numer_q;
    denom_d = denom_q;
    rem_d   = rem_q;
    quot_d  = quot_q;
    dbz_d   = dbz_q;
    case (ctrl.state)
      IDLE: begin
        // Zero-divisor results, ready for the short path
        quot_d = '1;
        rem_d  = operand_a_i;
        dbz_d  = divisor_zero_o;
      end
      ABS_A: begin
        numer_d = sign_a ? sub_res[XLEN-1:0] : operand_a_i;
        quot_d  = '0;
      end
      ABS_B: begin
        denom_d = sign_b ? sub_res[XLEN-1:0] : operand_b_i;
        // Seed with the dividend MSB
        rem_d   = {{(XLEN-1){1'b0}}, numer_q[XLEN-1]};
      end
      COMP: begin
        rem_d  = {next_rem[XLEN-2:0], numer_q[shift_idx]};
        quot_d = next_quot;
      end
      // Bit 0, no further shift
      LAST: begin
        rem_d  = next_rem;
        quot_d = next_quot;
      end
      CHANGE_SIGN: begin
        if (is_rem && rem_neg) begin
          rem_d = sub_res[XLEN-1:0];
        end
        if (!is_rem && quot_neg) begin
          quot_d = sub_res[XLEN-1:0];
        end
      end
      default: dbz_d = dbz_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      numer_q <= '0;
      denom_q <= '0;
      rem_q   <= '0;
      quot_q  <= '0;
      dbz_q   <= 1'b0;
    end else if (ctrl.step_en) begin
      numer_q <= numer_d;
      denom_q <= denom_d;
      rem_q   <= rem_d;
      quot_q  <= quot_d;
      dbz_q   <= dbz_d;
    end
  end

  assign ctrl.div_by_zero_q = dbz_q;
  assign result_o           = is_rem ? rem_q : quot_q;

  // Result frozen while the consumer stalls
  a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl.state == FINISH) && !ctrl.step_en |=> $stable(result_o));

endmodule

`default_nettype wire

// ==== logic/div_fsm.sv ====
//////////////////////////////////////////////////
// Divider FSM, sequences abs, compare and sign fix
// Takes the zero-divisor short path, holds FINISH
//////////////////////////////////////////////////

`default_nettype none

module div_fsm (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  div_pkg::div_op_e op_i,
  input  logic             divisor_zero_i,
  input  logic             data_ind_timing_i,
  input  logic             ready_i,
  div_ctrl_if.fsm_mp       ctrl,
  output logic             valid_o,
  output logic             busy_o
);

  import div_pkg::*;

  div_state_e state_q, state_d;
  logic       step_en;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        // Zero divisor skips iterations unless timing must not leak data
        if (start_i) begin
          state_d = (divisor_zero_i && !data_ind_timing_i) ? FINISH : ABS_A;
        end
      end
      ABS_A:       state_d = ABS_B;
      ABS_B:       state_d = COMP;
      COMP: begin
        if (ctrl.cnt_last) begin
          state_d = LAST;
        end
      end
      LAST:        state_d = CHANGE_SIGN;
      CHANGE_SIGN: state_d = FINISH;
      // Leaving FINISH is gated by step_en
      FINISH:      state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  // Only FINISH waits on the consumer
  assign step_en = (state_q != FINISH) | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (step_en) begin
      state_q <= state_d;
    end
  end

  assign ctrl.state   = state_q;
  assign ctrl.step_en = step_en;
  assign valid_o      = (state_q == FINISH);
  assign busy_o       = (state_q != IDLE);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Result offered until taken
  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && (state_q == FINISH));

  // Iterations end only through LAST
  a_comp_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == COMP) |=> (state_q inside {COMP, LAST}));

  // Datapath flag agrees with the short path decision
  a_short_path: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ABS_A) |-> data_ind_timing_i || !ctrl.div_by_zero_q);

  // Requester keeps the opcode for the whole division
  a_op_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != IDLE) |-> $stable(op_i));

endmodule

`default_nettype wire

// ==== logic/div_pkg.sv ====
//////////////////////////////////////////////////
// Shared types and widths for the serial divider
// Import inside module bodies, use scoped names in port lists
//////////////////////////////////////////////////

`default_nettype none

package div_pkg;

  // Operand and result width
  localparam int XLEN  = 32;
  // Wide enough to index every bit of an operand
  localparam int CNT_W = $clog2(XLEN);

  // Division opcodes
  typedef enum logic [1:0] {
    DIV,
    DIVU,
    REM,
    REMU
  } div_op_e;

  // Divider sequencing states
  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  // Signed variants take absolute values and fix signs at the end
  function automatic logic op_is_signed(div_op_e op);
    return (op == DIV) || (op == REM);
  endfunction

  // Remainder variants return the remainder register
  function automatic logic op_is_rem(div_op_e op);
    return (op == REM) || (op == REMU);
  endfunction

endpackage

`default_nettype wire

// ==== logic/serial_divider.sv ====
//////////////////////////////////////////////////
// Serial radix-2 divider, DIV/DIVU/REM/REMU
// Start strobe in, valid level out, ready from consumer
//////////////////////////////////////////////////

`default_nettype none

module serial_divider (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  div_pkg::div_op_e         op_i,
  input  logic [div_pkg::XLEN-1:0] operand_a_i,
  input  logic [div_pkg::XLEN-1:0] operand_b_i,
  input  logic                     data_ind_timing_i,
  input  logic                     ready_i,
  output logic [div_pkg::XLEN-1:0] result_o,
  output logic                     valid_o,
  output logic                     busy_o
);

  import div_pkg::*;

  // Control bundle between the units
  div_ctrl_if ctrl ();

  logic             divisor_zero;
  logic [CNT_W-1:0] bit_idx;

  div_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (start_i),
    .op_i              (op_i),
    .divisor_zero_i    (divisor_zero),
    .data_ind_timing_i (data_ind_timing_i),
    .ready_i           (ready_i),
    .ctrl              (ctrl.fsm_mp),
    .valid_o           (valid_o),
    .busy_o            (busy_o)
  );

  div_bit_counter u_bit_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ctrl      (ctrl.cnt_mp),
    .bit_idx_o (bit_idx)
  );

  div_datapath u_datapath (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl           (ctrl.dp_mp),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .bit_idx_i      (bit_idx),
    .divisor_zero_o (divisor_zero),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the serial divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=serial_divider_sim

verilator --binary --timing --assert -f serial_divider.f \
  --top-module serial_divider_tb -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== serial_divider.f ====
logic/div_pkg.sv
logic/div_ctrl_if.sv
logic/div_fsm.sv
logic/div_bit_counter.sv
logic/div_datapath.sv
logic/serial_divider.sv
testbench/tb_clock_gen.sv
testbench/serial_divider_tb.sv

// ==== testbench/serial_divider_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the serial divider
// Falling-edge stimulus, concurrent checks on the DUT
//////////////////////////////////////////////////

`default_nettype none

module serial_divider_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import div_pkg::*;

  localparam int N_RAND      = 40;
  localparam int N_STALL     = 8;
  localparam int MAX_STALL   = 8;
  // Random, overflow, zero divisor, stall and busy-start runs
  localparam int N_DIVS      = N_RAND + 2 + 8 + N_STALL + 1;
  localparam int DIV_CYCLES  = 40;
  localparam int WATCHDOG_NS = (N_DIVS * (DIV_CYCLES + MAX_STALL) + 100) * 8;

  logic            clk, rst_n;
  logic            start, dit, ready, valid, busy;
  logic            in_flight;
  div_op_e         op;
  logic [XLEN-1:0] opa, opb, result;
  logic [XLEN-1:0] exp_res, rnd;
  int              exp_lat, lat_cnt, stall;
  int              seed, err_cnt, err_mark, n_div, n_test;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  serial_divider uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .start_i           (start),
    .op_i              (op),
    .operand_a_i       (opa),
    .operand_b_i       (opb),
    .data_ind_timing_i (dit),
    .ready_i           (ready),
    .result_o          (result),
    .valid_o           (valid),
    .busy_o            (busy)
  );

  //////////////////////////////////////////////////
  // Reference model and reporting
  //////////////////////////////////////////////////

  // Plain division with the zero and overflow special cases
  function automatic logic [XLEN-1:0] ref_result(div_op_e d_op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa, sb, sq, sr;
    logic [XLEN-1:0]        res;
    logic                   ovf;
    sa  = a;
    sb  = b;
    sq  = '0;
    sr  = '0;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // Signed quotient and remainder outside the special cases
    if ((b != '0) && !ovf) begin
      sq = sa / sb;
      sr = sa % sb;
    end
    case (d_op)
      DIV:     res = (b == '0) ? '1 : (ovf ? a : sq);
      DIVU:    res = (b == '0) ? '1 : a / b;
      REM:     res = (b == '0) ? a : (ovf ? '0 : sr);
      default: res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  task automatic value_error(input string sig, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] expd);
    $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, sig, got, expd);
    err_cnt++;
  endtask

  task automatic plain_error(input string what);
    $display("Failure at %0d ns: %s", $time, what);
    err_cnt++;
  endtask

  task automatic end_test(input string name);
    n_test++;
    $display("Test %0d %s: %s, %0d errors", n_test, name,
             (err_cnt == err_mark) ? "ok" : "mismatch", err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // One division, optional consumer stall and a stray start while busy
  task automatic run_div(input div_op_e d_op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic timing_safe,
                         input int stall_len, input logic poke);
    int waited;
    waited = 0;
    @(negedge clk);
    op      = d_op;
    opa     = a;
    opb     = b;
    dit     = timing_safe;
    exp_res = ref_result(d_op, a, b);
    exp_lat = ((b == '0) && !timing_safe) ? 1 : 36;
    ready   = (stall_len == 0);
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (poke) begin
      repeat (4) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (!valid && waited < 60) begin
      @(negedge clk);
      waited++;
    end
    if (!valid) begin
      plain_error("valid_o never rose after start");
    end
    if (stall_len > 0) begin
      repeat (stall_len) @(negedge clk);
      ready = 1'b1;
    end
    // Past the ready edge and the edge that shows the release
    repeat (2) @(negedge clk);
    n_div++;
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Division in flight per the handshake, and edges since the accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
      lat_cnt   <= 0;
    end else if (start && !in_flight) begin
      in_flight <= 1'b1;
      lat_cnt   <= 1;
    end else if (in_flight) begin
      lat_cnt <= lat_cnt + 1;
      if (valid && ready) begin
        in_flight <= 1'b0;
      end
    end
  end

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(valid) |-> result == exp_res)
    else value_error("result_o", $sampled(result), $sampled(exp_res));

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(valid) |-> lat_cnt == exp_lat)
    else value_error("valid_o latency", $sampled(lat_cnt), $sampled(exp_lat));

  // Busy from the accepting edge until the ready cycle
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy == in_flight)
    else value_error("busy_o", $sampled(busy), $sampled(in_flight));

  // Back-pressure holds both the level and the data
  a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
    valid && !ready |=> valid)
    else plain_error("valid_o dropped while ready_i was low");

  a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
    valid && !ready |=> result == exp_res)
    else value_error("result_o", $sampled(result), $sampled(exp_res));

  a_release: assert property (@(posedge clk) disable iff (!rst_n)
    valid && ready |=> !valid)
    else plain_error("valid_o stayed high after the ready cycle");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    seed     = 32'h44f7;
    start    = 1'b0;
    op       = DIV;
    opa      = '0;
    opb      = '0;
    dit      = 1'b0;
    ready    = 1'b1;
    err_cnt  = 0;
    err_mark = 0;
    n_div    = 0;
    n_test   = 0;
    wait (rst_n === 1'b1);

    // Divisor magnitude varied by a random shift
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      run_div(div_op_e'(rnd[1:0]), $random(seed), $unsigned($random(seed)) >> rnd[8:4],
              1'b0, 0, 1'b0);
    end
    end_test("random ops and latency");

    run_div(DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0, 0, 1'b0);
    run_div(REM, 32'h8000_0000, 32'hffff_ffff, 1'b0, 0, 1'b0);
    end_test("signed overflow");

    // Bit 2 picks the timing mode
    for (int k = 0; k < 8; k++) begin
      run_div(div_op_e'(k[1:0]), $random(seed), '0, k[2], 0, 1'b0);
    end
    end_test("zero divisor");

    for (int j = 0; j < N_STALL; j++) begin
      stall = 1 + ($unsigned($random(seed)) % MAX_STALL);
      run_div(div_op_e'(j[1:0]), $random(seed), $random(seed), 1'b0, stall, 1'b0);
    end
    end_test("consumer stall");

    run_div(DIV, 32'hfedc_ba98, 32'h0000_0123, 1'b0, 0, 1'b1);
    end_test("start while busy");

    $display("Summary: %0d tests, %0d divisions, %0d errors", n_test, n_div, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Bounded by the longest division plus the worst stall
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset source
// 8 ns clock, active low reset held for 3 cycles
//////////////////////////////////////////////////

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, away from the flops
  initial begin
    rst_no = 1'b0;
    #(RST_CYCLES * PERIOD_NS) rst_no = 1'b1;
  end

endmodule

`default_nettype wire
